// File: sm83_alu_pkg.sv
`default_nettype none

package sm83_alu_pkg;

	// Register offsets on the APB address bus.
	// Each register sits on its own word.
	localparam logic [3:0] REG_A   = 4'h0;
	localparam logic [3:0] REG_B   = 4'h4;
	localparam logic [3:0] REG_CMD = 4'h8;
	localparam logic [3:0] REG_F   = 4'hC;

	// Accumulator operations, taken from opcode bits 5:3 as on the SM83.
	localparam logic [2:0] OP_ADD = 3'd0;
	localparam logic [2:0] OP_ADC = 3'd1;
	localparam logic [2:0] OP_SUB = 3'd2;
	localparam logic [2:0] OP_SBC = 3'd3;
	localparam logic [2:0] OP_AND = 3'd4;
	localparam logic [2:0] OP_XOR = 3'd5;
	localparam logic [2:0] OP_OR  = 3'd6;
	localparam logic [2:0] OP_CP  = 3'd7;

	// Prefixed (CB) rotate and shift operations, also in bits 5:3.
	localparam logic [2:0] CB_RLC  = 3'd0;
	localparam logic [2:0] CB_RRC  = 3'd1;
	localparam logic [2:0] CB_RL   = 3'd2;
	localparam logic [2:0] CB_RR   = 3'd3;
	localparam logic [2:0] CB_SLA  = 3'd4;
	localparam logic [2:0] CB_SRA  = 3'd5;
	localparam logic [2:0] CB_SWAP = 3'd6;
	localparam logic [2:0] CB_SRL  = 3'd7;

	// Jump conditions in opcode bits 4:3.
	localparam logic [1:0] CC_NZ = 2'd0;
	localparam logic [1:0] CC_Z  = 2'd1;
	localparam logic [1:0] CC_NC = 2'd2;
	localparam logic [1:0] CC_C  = 2'd3;

	// The two halves of the DAA correction.
	localparam logic [7:0] DAA_LOW  = 8'h06;
	localparam logic [7:0] DAA_HIGH = 8'h60;

	// Requester side of the APB port.
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;
		logic [15:0] pwdata;
	} apb_req_t;

	// Completer side of the APB port.
	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [15:0] prdata;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		CLS_ALU  = 2'd0,
		CLS_CB   = 2'd1,
		CLS_DAA  = 2'd2,
		CLS_COND = 2'd3
	} alu_class_t;

	// Opcode as seen by the accumulator and CB decoders.
	typedef struct packed {
		logic [1:0] grp;
		logic [2:0] op543;
		logic [2:0] reg_sel;
	} op_view_t;

	// Opcode as seen by the conditional jump decoder.
	typedef struct packed {
		logic [2:0] jgrp;
		logic [1:0] cc;
		logic [2:0] jlow;
	} jump_view_t;

	// The same opcode byte, decoded one of two ways depending on the class.
	typedef union packed {
		op_view_t   op;
		jump_view_t jump;
	} opcode_u;

	typedef struct packed {
		alu_class_t cls;
		opcode_u    opcode;
	} cmd_t;

	// Flags in the order they occupy F[7:4].
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flags_t;

	typedef struct packed {
		logic [7:0] result;
		flags_t     flags;
		logic       shift_out;
	} alu_res_t;

endpackage

`default_nettype wire

// File: sm83_alu_control.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_control import sm83_alu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  cmd_t       cmd,
	input  logic       cmd_valid,
	input  flags_t     flags_q,
	input  alu_res_t   core_res,
	input  alu_res_t   shift_res,
	input  logic       daa_l_gt_9,
	input  logic       daa_h_gt_9,
	input  logic       daa_h_eq_9,
	output logic       shift_l,
	output logic       shift_r,
	output logic       shift_in,
	output logic [7:0] daa_out,
	output logic       a_sel,
	output alu_res_t   res,
	output logic       a_we,
	output logic       f_we,
	output logic       cond_we,
	output logic       cond_result
);

	logic       is_cb;
	logic [2:0] op543;
	logic       daa_low;
	logic       daa_carry;

	assign is_cb = (cmd.cls == CLS_CB);
	assign op543 = cmd.opcode.op.op543;

	// SWAP is the only CB operation that does not move bits by one place.
	// It is routed to the shifter as its nibble-swap select.
	assign a_sel = is_cb && (op543 == CB_SWAP);

	// Odd CB operations shift right, even ones shift left.
	assign shift_l = is_cb && !a_sel && !op543[0];
	assign shift_r = is_cb && !a_sel && op543[0];

	// The core passes A through unchanged for CB commands.
	// Its result therefore supplies the end bits of A for the shift carry.
	always_comb begin
		case (op543)
			CB_RLC, CB_SRA: shift_in = core_res.result[7];
			CB_RRC:         shift_in = core_res.result[0];
			CB_RL, CB_RR:   shift_in = flags_q.c;
			CB_SLA, CB_SRL: shift_in = 1'b0;
			// SWAP moves no single bit in.
			default:        shift_in = 1'b0;
		endcase
	end

	// After an addition the low nibble needs a correction when it went past 9
	// or produced a half carry. After a subtraction only the flag counts.
	assign daa_low = flags_q.h || (!flags_q.n && daa_l_gt_9);

	// The high correction also sets the carry, since A went past 0x99.
	assign daa_carry = flags_q.c ||
		(!flags_q.n && (daa_h_gt_9 || (daa_l_gt_9 && daa_h_eq_9)));

	assign daa_out = (daa_low ? DAA_LOW : 8'h00) | (daa_carry ? DAA_HIGH : 8'h00);

	// Pick the datapath result for write-back.
	// DAA takes its carry from the correction logic here, not from the adder.
	always_comb begin
		res = core_res;
		if (is_cb) begin
			res = shift_res;
		end else if (cmd.cls == CLS_DAA) begin
			res.flags.c = daa_carry;
		end
	end

	// CP only compares, so A keeps its value.
	// A condition test touches neither A nor F.
	assign a_we = (cmd.cls != CLS_COND) &&
		!((cmd.cls == CLS_ALU) && (op543 == OP_CP));
	assign f_we = (cmd.cls != CLS_COND);
	assign cond_we = cmd_valid && (cmd.cls == CLS_COND);

	// The condition bit holds until the next condition command.
	always_ff @(posedge clk) begin
		if (reset) begin
			cond_result <= 1'b0;
		end else if (cond_we) begin
			case (cmd.opcode.jump.cc)
				CC_NZ:   cond_result <= !flags_q.z;
				CC_Z:    cond_result <= flags_q.z;
				CC_NC:   cond_result <= !flags_q.c;
				CC_C:    cond_result <= flags_q.c;
				default: cond_result <= 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sm83_alu_core.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_core import sm83_alu_pkg::*; (
	input  logic [7:0] a_q,
	input  logic [7:0] b_q,
	input  flags_t     flags_q,
	input  cmd_t       cmd,
	input  logic [7:0] daa_out,
	output alu_res_t   core_res,
	output logic       daa_l_gt_9,
	output logic       daa_h_gt_9,
	output logic       daa_h_eq_9
);

	logic       is_daa;
	logic [2:0] op543;
	logic       sub;
	logic       cin;
	logic [7:0] opnd;
	logic [7:0] opnd_x;
	logic [4:0] sum_lo;
	logic [4:0] sum_hi;
	logic       half;
	logic       carry;
	logic [7:0] value;
	flags_t     flags;

	assign is_daa = (cmd.cls == CLS_DAA);
	assign op543  = cmd.opcode.op.op543;

	// DAA subtracts its correction when the last operation was a subtraction.
	assign sub = is_daa ? flags_q.n :
		(op543 == OP_SUB) || (op543 == OP_SBC) || (op543 == OP_CP);
	assign cin = !is_daa && ((op543 == OP_ADC) || (op543 == OP_SBC)) && flags_q.c;

	// The second operand is B, or the correction byte for DAA.
	assign opnd = is_daa ? daa_out : b_q;

	// Subtraction is A + ~B + !cin.
	// The raw carries come out inverted and are turned into borrows below.
	assign opnd_x = opnd ^ {8{sub}};
	assign sum_lo = {1'b0, a_q[3:0]} + {1'b0, opnd_x[3:0]} + {4'b0, cin ^ sub};
	assign sum_hi = {1'b0, a_q[7:4]} + {1'b0, opnd_x[7:4]} + {4'b0, sum_lo[4]};

	// Half carry is the carry out of the low stage.
	assign half  = sum_lo[4] ^ sub;
	assign carry = sum_hi[4] ^ sub;

	always_comb begin
		value = a_q;
		flags = flags_q;
		case (cmd.cls)
			CLS_ALU: begin
				case (op543)
					OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP: begin
						value = {sum_hi[3:0], sum_lo[3:0]};
						flags.h = half;
						flags.c = carry;
					end
					OP_AND: begin
						value = a_q & b_q;
						flags.h = 1'b1;
						flags.c = 1'b0;
					end
					OP_XOR: begin
						value = a_q ^ b_q;
						flags.h = 1'b0;
						flags.c = 1'b0;
					end
					OP_OR: begin
						value = a_q | b_q;
						flags.h = 1'b0;
						flags.c = 1'b0;
					end
					default: value = a_q;
				endcase
				flags.n = sub;
				flags.z = ({sum_hi[3:0], sum_lo[3:0]} == 8'h00);
				// Logic results need their own zero test.
				if (op543 == OP_AND || op543 == OP_XOR || op543 == OP_OR) begin
					flags.z = (value == 8'h00);
				end
			end
			CLS_DAA: begin
				// N and C are kept here.
				// The control block supplies the final carry.
				value = {sum_hi[3:0], sum_lo[3:0]};
				flags.z = (value == 8'h00);
				flags.h = 1'b0;
			end
			// CB and condition commands see A and F unchanged.
			default: value = a_q;
		endcase
	end

	assign core_res.result    = value;
	assign core_res.flags     = flags;
	// The adder never shifts a bit out.
	assign core_res.shift_out = 1'b0;

	// Nibble comparisons of A that drive the DAA correction.
	assign daa_l_gt_9 = (a_q[3:0] > 4'd9);
	assign daa_h_gt_9 = (a_q[7:4] > 4'd9);
	assign daa_h_eq_9 = (a_q[7:4] == 4'd9);

endmodule

`default_nettype wire

// File: sm83_alu_shifter.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_shifter import sm83_alu_pkg::*; (
	input  logic [7:0] a_q,
	input  logic       shift_l,
	input  logic       shift_r,
	input  logic       shift_in,
	input  logic       swap,
	output alu_res_t   shift_res
);

	logic [7:0] value;
	logic       out_bit;

	// Only one of swap, shift_l and shift_r is set for a given command.
	always_comb begin
		value   = a_q;
		out_bit = 1'b0;
		if (swap) begin
			value = {a_q[3:0], a_q[7:4]};
		end else if (shift_l) begin
			// Bit 7 leaves and shift_in enters at bit 0.
			value   = {a_q[6:0], shift_in};
			out_bit = a_q[7];
		end else if (shift_r) begin
			// Bit 0 leaves and shift_in enters at bit 7.
			value   = {shift_in, a_q[7:1]};
			out_bit = a_q[0];
		end
	end

	assign shift_res.result    = value;
	assign shift_res.flags.z   = (value == 8'h00);
	assign shift_res.flags.n   = 1'b0;
	assign shift_res.flags.h   = 1'b0;
	// The carry takes the bit that fell off, which SWAP never produces.
	assign shift_res.flags.c   = out_bit;
	assign shift_res.shift_out = out_bit;

endmodule

`default_nettype wire

// File: sm83_alu_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_regs import sm83_alu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  apb_req_t   apb_req,
	output apb_rsp_t   apb_rsp,
	input  alu_res_t   res,
	input  logic       a_we,
	input  logic       f_we,
	input  logic       cond_result,
	output cmd_t       cmd,
	output logic       cmd_valid,
	output logic [7:0] a_q,
	output logic [7:0] b_q,
	output flags_t     flags_q
);

	logic wr_en;
	logic wr_a;
	logic wr_b;
	logic wr_cmd;
	logic wr_f;

	// A write completes in its access phase, because pready is always high.
	assign wr_en  = apb_req.psel && apb_req.penable && apb_req.pwrite;
	assign wr_a   = wr_en && (apb_req.paddr == REG_A);
	assign wr_b   = wr_en && (apb_req.paddr == REG_B);
	assign wr_cmd = wr_en && (apb_req.paddr == REG_CMD);
	assign wr_f   = wr_en && (apb_req.paddr == REG_F);

	always_ff @(posedge clk) begin
		if (reset) begin
			a_q       <= 8'h00;
			b_q       <= 8'h00;
			flags_q   <= '0;
			cmd_valid <= 1'b0;
		end else begin
			// The strobe lasts exactly one cycle after the CMD access.
			cmd_valid <= wr_cmd;
			// A result from the datapath wins over a host write in the same cycle.
			if (cmd_valid && a_we) begin
				a_q <= res.result;
			end else if (wr_a) begin
				a_q <= apb_req.pwdata[7:0];
			end
			if (wr_b) begin
				b_q <= apb_req.pwdata[7:0];
			end
			if (cmd_valid && f_we) begin
				flags_q <= res.flags;
			end else if (wr_f) begin
				flags_q <= apb_req.pwdata[7:4];
			end
		end
	end

	// The command is staged here and consumed while cmd_valid is high.
	always_ff @(posedge clk) begin
		if (wr_cmd) begin
			cmd <= cmd_t'(apb_req.pwdata[9:0]);
		end
	end

	// Reads are plain multiplexing with no side effects.
	always_comb begin
		apb_rsp.pready  = 1'b1;
		apb_rsp.pslverr = 1'b0;
		case (apb_req.paddr)
			REG_A:   apb_rsp.prdata = {8'h00, a_q};
			REG_B:   apb_rsp.prdata = {8'h00, b_q};
			REG_CMD: apb_rsp.prdata = {6'b0, cmd};
			// The condition bit rides above the flags in F.
			REG_F:   apb_rsp.prdata = {7'b0, cond_result, flags_q, 4'b0};
			default: apb_rsp.prdata = 16'h0000;
		endcase
	end

endmodule

`default_nettype wire

// File: sm83_alu_top.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_top import sm83_alu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	cmd_t       cmd;
	logic       cmd_valid;
	logic [7:0] a_q;
	logic [7:0] b_q;
	flags_t     flags_q;
	alu_res_t   core_res;
	alu_res_t   shift_res;
	alu_res_t   res;
	logic       daa_l_gt_9;
	logic       daa_h_gt_9;
	logic       daa_h_eq_9;
	logic       shift_l;
	logic       shift_r;
	logic       shift_in;
	logic [7:0] daa_out;
	logic       a_sel;
	logic       a_we;
	logic       f_we;
	logic       cond_result;

	sm83_alu_regs sm83_alu_regs_inst (
		.clk         (clk),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.res         (res),
		.a_we        (a_we),
		.f_we        (f_we),
		.cond_result (cond_result),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.a_q         (a_q),
		.b_q         (b_q),
		.flags_q     (flags_q)
	);

	// The condition enable is consumed inside the control block itself.
	sm83_alu_control sm83_alu_control_inst (
		.clk         (clk),
		.reset       (reset),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.flags_q     (flags_q),
		.core_res    (core_res),
		.shift_res   (shift_res),
		.daa_l_gt_9  (daa_l_gt_9),
		.daa_h_gt_9  (daa_h_gt_9),
		.daa_h_eq_9  (daa_h_eq_9),
		.shift_l     (shift_l),
		.shift_r     (shift_r),
		.shift_in    (shift_in),
		.daa_out     (daa_out),
		.a_sel       (a_sel),
		.res         (res),
		.a_we        (a_we),
		.f_we        (f_we),
		.cond_we     (),
		.cond_result (cond_result)
	);

	sm83_alu_core sm83_alu_core_inst (
		.a_q        (a_q),
		.b_q        (b_q),
		.flags_q    (flags_q),
		.cmd        (cmd),
		.daa_out    (daa_out),
		.core_res   (core_res),
		.daa_l_gt_9 (daa_l_gt_9),
		.daa_h_gt_9 (daa_h_gt_9),
		.daa_h_eq_9 (daa_h_eq_9)
	);

	sm83_alu_shifter sm83_alu_shifter_inst (
		.a_q       (a_q),
		.shift_l   (shift_l),
		.shift_r   (shift_r),
		.shift_in  (shift_in),
		.swap      (a_sel),
		.shift_res (shift_res)
	);

endmodule

`default_nettype wire

// File: sm83_alu_checker.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_checker import sm83_alu_pkg::*; (
	input logic       clk,
	input logic       reset,
	input apb_req_t   apb_req,
	input logic       cmd_valid,
	input logic [7:0] a_q,
	input logic [7:0] b_q,
	input flags_t     flags_q
);

	logic cmd_access;

	// The access phase of a write to CMD, taken straight from the bus.
	assign cmd_access = apb_req.psel && apb_req.penable && apb_req.pwrite &&
		(apb_req.paddr == REG_CMD);

	// An access phase always comes right after a setup phase.
	assert property (@(posedge clk) disable iff (reset)
		(apb_req.psel && apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
		else $error("access phase without a setup phase");

	// The command strobe follows a CMD write by one cycle and lasts one cycle.
	assert property (@(posedge clk) disable iff (reset) cmd_access |=> cmd_valid)
		else $error("cmd_valid missing after CMD write");
	assert property (@(posedge clk) disable iff (reset) cmd_valid |-> $past(cmd_access))
		else $error("cmd_valid without a CMD write");
	assert property (@(posedge clk) disable iff (reset) cmd_valid |=> !cmd_valid)
		else $error("cmd_valid held for more than one cycle");

	// Registers come out of reset cleared.
	assert property (@(posedge clk) $fell(reset) |->
		(a_q == 8'h00 && b_q == 8'h00 && flags_q == 4'h0 && !cmd_valid))
		else $error("registers not zero after reset");

endmodule

bind sm83_alu_regs sm83_alu_checker sm83_alu_checker_inst (
	.clk       (clk),
	.reset     (reset),
	.apb_req   (apb_req),
	.cmd_valid (cmd_valid),
	.a_q       (a_q),
	.b_q       (b_q),
	.flags_q   (flags_q)
);

`default_nettype wire

// File: sm83_alu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sm83_alu_tb import sm83_alu_pkg::*; ();

	// One table row: class, opcode, operands, flags in, expected A, F and condition bit.
	typedef struct packed {
		logic [1:0] cls;
		logic [7:0] opc;
		logic [7:0] a;
		logic [7:0] b;
		logic [3:0] f;
		logic [7:0] exp_a;
		logic [3:0] exp_f;
		logic       exp_cond;
	} row_t;

	localparam int RANDOM_CMDS = 200;
	localparam int PERIOD      = 20;

	logic     clk;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	row_t     rows[$];
	int       errors;
	logic [31:0] rng;

	sm83_alu_top sm83_alu_top_inst (
		.clk     (clk),
		.reset   (reset),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Each command takes six APB transfers of two cycles each.
	// The table is complete by the first edge, so its size is known there.
	initial begin
		@(posedge clk);
		#((rows.size() + RANDOM_CMDS) * 12 * PERIOD + 5000);
		$display("timeout: the run did not finish in the expected time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Reference model of the SM83 rules; returns {cond, A, flags}.
	function automatic logic [12:0] reference_model(input logic [1:0] cls, input logic [7:0] opc,
			input logic [7:0] a, input logic [7:0] b, input logic [3:0] f, input logic cond);
		logic       z, n, h, c, cin, dc;
		logic [7:0] r;
		logic [8:0] wide;
		logic [7:0] corr;
		{z, n, h, c} = f;
		r = a;
		case (cls)
			2'd0: begin
				cin = ((opc[5:3] == 3'd1) || (opc[5:3] == 3'd3)) && c;
				case (opc[5:3])
					3'd0, 3'd1: begin
						wide = {1'b0, a} + {1'b0, b} + cin;
						h = (int'(a[3:0]) + int'(b[3:0]) + int'(cin)) > 15;
						r = wide[7:0];
						c = wide[8];
						n = 1'b0;
					end
					3'd2, 3'd3, 3'd7: begin
						h = int'(a[3:0]) < int'(b[3:0]) + int'(cin);
						c = int'(a) < int'(b) + int'(cin);
						r = a - b - cin;
						n = 1'b1;
					end
					3'd4: begin
						r = a & b;
						{n, h, c} = 3'b010;
					end
					3'd5: begin
						r = a ^ b;
						{n, h, c} = 3'b000;
					end
					default: begin
						r = a | b;
						{n, h, c} = 3'b000;
					end
				endcase
				z = (r == 8'h00);
				// Compare leaves A as it was.
				if (opc[5:3] == 3'd7) r = a;
			end
			2'd1: begin
				case (opc[5:3])
					3'd0: r = {a[6:0], a[7]};
					3'd1: r = {a[0], a[7:1]};
					3'd2: r = {a[6:0], c};
					3'd3: r = {c, a[7:1]};
					3'd4: r = {a[6:0], 1'b0};
					3'd5: r = {a[7], a[7:1]};
					3'd6: r = {a[3:0], a[7:4]};
					default: r = {1'b0, a[7:1]};
				endcase
				// Left moves lose bit 7, right moves lose bit 0.
				if (opc[5:3] == 3'd6) c = 1'b0;
				else c = opc[3] ? a[0] : a[7];
				z = (r == 8'h00);
				n = 1'b0;
				h = 1'b0;
			end
			2'd2: begin
				corr = 8'h00;
				dc = c;
				if (h || (!n && a[3:0] > 4'd9)) corr = corr | 8'h06;
				if (c || (!n && a > 8'h99)) begin
					corr = corr | 8'h60;
					dc = 1'b1;
				end
				r = n ? a - corr : a + corr;
				z = (r == 8'h00);
				h = 1'b0;
				c = dc;
			end
			default: begin
				case (opc[4:3])
					2'd0: cond = !z;
					2'd1: cond = z;
					2'd2: cond = !c;
					default: cond = c;
				endcase
			end
		endcase
		return {cond, r, z, n, h, c};
	endfunction

	task automatic apb_write(input logic [3:0] addr, input logic [15:0] data);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(posedge clk);
		#2 apb_req.penable = 1'b1;
		@(negedge clk);
		check_response();
		@(posedge clk);
		#2 apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	// The read data is sampled at the falling edge, away from register updates.
	task automatic apb_read(input logic [3:0] addr, output logic [15:0] data);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		@(posedge clk);
		#2 apb_req.penable = 1'b1;
		@(negedge clk);
		data = apb_rsp.prdata;
		check_response();
		@(posedge clk);
		#2 apb_req.psel = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Every access phase completes at once and without an error.
	task automatic check_response();
		check_value({14'b0, apb_rsp.pready, apb_rsp.pslverr}, 16'h0002, "pready and pslverr");
	endtask

	task automatic run_command(input row_t row);
		logic [15:0] data;
		apb_write(REG_A, {8'h00, row.a});
		apb_write(REG_B, {8'h00, row.b});
		apb_write(REG_F, {8'h00, row.f, 4'h0});
		apb_write(REG_CMD, {6'b0, row.cls, row.opc});
		apb_read(REG_A, data);
		check_value(data, {8'h00, row.exp_a}, $sformatf("A after cls %0d op %h", row.cls, row.opc));
		apb_read(REG_F, data);
		check_value(data, {7'b0, row.exp_cond, row.exp_f, 4'h0},
			$sformatf("F after cls %0d op %h", row.cls, row.opc));
	endtask

	task automatic add_row(input logic [1:0] cls, input logic [7:0] opc, input logic [7:0] a,
			input logic [7:0] b, input logic [3:0] f, input logic [7:0] exp_a,
			input logic [3:0] exp_f, input logic exp_cond);
		rows.push_back('{cls, opc, a, b, f, exp_a, exp_f, exp_cond});
	endtask

	initial begin
		// Accumulator operations; flags are z, n, h, c.
		add_row(2'd0, 8'h80, 8'h0F, 8'h01, 4'b0000, 8'h10, 4'b0010, 1'b0);
		add_row(2'd0, 8'h80, 8'hF0, 8'h10, 4'b0000, 8'h00, 4'b1001, 1'b0);
		add_row(2'd0, 8'h88, 8'h12, 8'h34, 4'b0001, 8'h47, 4'b0000, 1'b0);
		add_row(2'd0, 8'h90, 8'h10, 8'h01, 4'b0000, 8'h0F, 4'b0110, 1'b0);
		add_row(2'd0, 8'h98, 8'h10, 8'h10, 4'b0001, 8'hFF, 4'b0111, 1'b0);
		add_row(2'd0, 8'hB8, 8'h42, 8'h42, 4'b0000, 8'h42, 4'b1100, 1'b0);
		add_row(2'd0, 8'hA0, 8'hF0, 8'h0F, 4'b0000, 8'h00, 4'b1010, 1'b0);
		add_row(2'd0, 8'hA8, 8'hAA, 8'h55, 4'b1111, 8'hFF, 4'b0000, 1'b0);
		add_row(2'd0, 8'hB0, 8'h00, 8'h00, 4'b1111, 8'h00, 4'b1000, 1'b0);
		// Prefixed rotates and shifts.
		add_row(2'd1, 8'h07, 8'h85, 8'h00, 4'b0000, 8'h0B, 4'b0001, 1'b0);
		add_row(2'd1, 8'h0F, 8'h01, 8'h00, 4'b0000, 8'h80, 4'b0001, 1'b0);
		add_row(2'd1, 8'h17, 8'h80, 8'h00, 4'b0001, 8'h01, 4'b0001, 1'b0);
		add_row(2'd1, 8'h17, 8'h80, 8'h00, 4'b0000, 8'h00, 4'b1001, 1'b0);
		add_row(2'd1, 8'h1F, 8'h01, 8'h00, 4'b0001, 8'h80, 4'b0001, 1'b0);
		add_row(2'd1, 8'h27, 8'h81, 8'h00, 4'b0000, 8'h02, 4'b0001, 1'b0);
		add_row(2'd1, 8'h2F, 8'h81, 8'h00, 4'b0000, 8'hC0, 4'b0001, 1'b0);
		add_row(2'd1, 8'h37, 8'hF1, 8'h00, 4'b0001, 8'h1F, 4'b0000, 1'b0);
		add_row(2'd1, 8'h3F, 8'h01, 8'h00, 4'b0000, 8'h00, 4'b1001, 1'b0);
		// DAA after additions, then after subtractions.
		add_row(2'd2, 8'h27, 8'h45, 8'h00, 4'b0000, 8'h45, 4'b0000, 1'b0);
		add_row(2'd2, 8'h27, 8'h4C, 8'h00, 4'b0000, 8'h52, 4'b0000, 1'b0);
		add_row(2'd2, 8'h27, 8'hA2, 8'h00, 4'b0000, 8'h02, 4'b0001, 1'b0);
		add_row(2'd2, 8'h27, 8'h9A, 8'h00, 4'b0000, 8'h00, 4'b1001, 1'b0);
		add_row(2'd2, 8'h27, 8'h0F, 8'h00, 4'b0110, 8'h09, 4'b0100, 1'b0);
		add_row(2'd2, 8'h27, 8'hF0, 8'h00, 4'b0101, 8'h90, 4'b0101, 1'b0);
		add_row(2'd2, 8'h27, 8'hEE, 8'h00, 4'b0111, 8'h88, 4'b0101, 1'b0);
		add_row(2'd2, 8'h27, 8'h33, 8'h00, 4'b0100, 8'h33, 4'b0100, 1'b0);
		// Conditions NZ, Z, NC and C against both flag states.
		add_row(2'd3, 8'hC2, 8'h5A, 8'h00, 4'b0000, 8'h5A, 4'b0000, 1'b1);
		add_row(2'd3, 8'hC2, 8'h5A, 8'h00, 4'b1000, 8'h5A, 4'b1000, 1'b0);
		add_row(2'd3, 8'hCA, 8'h5A, 8'h00, 4'b1000, 8'h5A, 4'b1000, 1'b1);
		add_row(2'd3, 8'hCA, 8'h5A, 8'h00, 4'b0000, 8'h5A, 4'b0000, 1'b0);
		add_row(2'd3, 8'hD2, 8'h5A, 8'h00, 4'b0000, 8'h5A, 4'b0000, 1'b1);
		add_row(2'd3, 8'hD2, 8'h5A, 8'h00, 4'b0001, 8'h5A, 4'b0001, 1'b0);
		add_row(2'd3, 8'hDA, 8'h5A, 8'h00, 4'b0001, 8'h5A, 4'b0001, 1'b1);
		add_row(2'd3, 8'hDA, 8'h5A, 8'h00, 4'b0000, 8'h5A, 4'b0000, 1'b0);
	end

	initial begin
		logic [15:0] data;
		logic [12:0] exp;
		logic        cond_state;
		row_t        row;
		clk     = 1'b0;
		reset   = 1'b1;
		apb_req = '0;
		errors  = 0;
		rng     = 32'd40821;
		repeat (2) @(posedge clk);
		#2 reset = 1'b0;

		// Registers read zero after reset, and B reads back what was written.
		apb_read(REG_A, data);
		check_value(data, 16'h0000, "A after reset");
		apb_read(REG_B, data);
		check_value(data, 16'h0000, "B after reset");
		apb_read(REG_F, data);
		check_value(data, 16'h0000, "F after reset");
		apb_write(REG_B, 16'h00A5);
		apb_read(REG_B, data);
		check_value(data, 16'h00A5, "B readback");

		foreach (rows[i]) begin
			run_command(rows[i]);
		end
		row = rows[rows.size() - 1];
		cond_state = row.exp_cond;

		// CMD holds the last command that was written.
		apb_read(REG_CMD, data);
		check_value(data, {6'b0, row.cls, row.opc}, "CMD readback");

		for (int i = 0; i < RANDOM_CMDS; i++) begin
			rng = xorshift(rng);
			row.cls = rng[1:0];
			row.a   = rng[15:8];
			row.b   = rng[23:16];
			row.f   = rng[27:24];
			case (row.cls)
				2'd0: row.opc = {2'b10, rng[30:28], 3'b111};
				2'd1: row.opc = {2'b00, rng[30:28], 3'b111};
				2'd2: row.opc = 8'h27;
				default: row.opc = {3'b110, rng[29:28], 3'b010};
			endcase
			exp = reference_model(row.cls, row.opc, row.a, row.b, row.f, cond_state);
			{row.exp_cond, row.exp_a, row.exp_f} = exp;
			cond_state = exp[12];
			run_command(row);
		end

		$display("errors: %0d in %0d table rows and %0d random commands",
			errors, rows.size(), RANDOM_CMDS);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
sm83_alu_pkg.sv
sm83_alu_control.sv
sm83_alu_core.sv
sm83_alu_shifter.sv
sm83_alu_regs.sv
sm83_alu_top.sv
sm83_alu_checker.sv
sm83_alu_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := sm83_alu_tb
FILELIST  := tb.f
SOURCES   := $(shell cat $(FILELIST))
BIN       := obj_dir/V$(TOP)
LOG       := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	! grep -q "SOME TESTS FAILED" $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
